// File: common/rx_os_pkg.sv
// rx_os package with version, block and register map, bus and status structs, sample union
package rx_os_pkg;

  // ******************************
  // identification
  // ******************************

  // read-only version word
  localparam logic [31:0] rx_os_version = 32'h0001_0061;

  // ******************************
  // address map
  // ******************************

  // block number, address bits 13:8
  localparam logic [5:0] blk_common = 6'd0;
  localparam logic [5:0] blk_chan0 = 6'd1;
  localparam logic [5:0] blk_chan1 = 6'd2;

  // common block offsets, address bits 7:0
  localparam logic [7:0] reg_version = 8'h00;
  localparam logic [7:0] reg_scratch = 8'h01;
  localparam logic [7:0] reg_rst_ctrl = 8'h02;
  localparam logic [7:0] reg_status = 8'h03;
  localparam logic [7:0] reg_dma_status = 8'h04;

  // channel block offsets
  localparam logic [7:0] reg_chan_ctrl = 8'h00;
  localparam logic [7:0] reg_chan_status = 8'h01;

  // pn monitor, run length that flips the oos state
  localparam logic [2:0] pn_lock_count = 3'd4;

  // ******************************
  // processor bus
  // ******************************

  // request, fanned out to every peer
  typedef struct packed {
    logic        wreq;
    logic [13:0] waddr;
    logic [31:0] wdata;
    logic        rreq;
    logic [13:0] raddr;
  } up_req_t;

  // response, zero when the peer is not addressed
  typedef struct packed {
    logic        wack;
    logic [31:0] rdata;
    logic        rack;
  } up_rsp_t;

  // ******************************
  // channel status and samples
  // ******************************

  // per channel sticky status
  typedef struct packed {
    logic pn_err;
    logic pn_oos;
    logic over_range;
  } chan_status_t;

  // two samples per channel word, s0 is the older one
  typedef struct packed {
    logic [15:0] s1;
    logic [15:0] s0;
  } sample_pair_t;

  // raw view for transport, pair view for per-sample work
  typedef union packed {
    logic [31:0]  raw;
    sample_pair_t pair;
  } sample_word_t;

endpackage

// File: hw/rx_os_level_sync.sv
// two-flop level synchronizer for a group of slow control and status bits
module rx_os_level_sync #(
  parameter int width = 2
) (
  input  logic             clk,
  input  logic [width-1:0] d,
  output logic [width-1:0] q
);

  // first stage, may go metastable
  logic [width-1:0] meta;

  // ******************************
  // synchronizer chain
  // ******************************

  // levels only, each bit settles on its own
  always_ff @(posedge clk) begin
    meta <= d;
    q <= meta;
  end

endmodule

// File: rx_os_channel/rx_os_pn_mon.sv
// pn15 monitor with self-sync, out-of-sync tracking and sticky error
module rx_os_pn_mon import rx_os_pkg::*; (
  input  logic         adc_os_clk,
  input  logic         adc_os_rst,
  input  logic         valid,
  input  sample_word_t word,
  output logic         pn_err,
  output logic         pn_oos
);

  // s1 of the previous valid word
  logic [15:0] last_s1;
  // both samples follow the sequence
  logic        match;
  // consecutive words pushing toward a state change
  logic [2:0]  run;

  // ******************************
  // pn15 successor
  // ******************************

  // x^15 + x^14 + 1, bit 0 holds the newest bit
  // sixteen steps give the next 16-bit sample
  function automatic logic [15:0] pn15_next(input logic [15:0] d);
    logic [15:0] r;
    r = d;
    for (int i = 0; i < 16; i++) begin
      r = {r[14:0], r[14] ^ r[13]};
    end
    return r;
  endfunction

  // s0 follows last word's s1, s1 follows s0
  assign match = (word.pair.s0 == pn15_next(last_s1)) &&
                 (word.pair.s1 == pn15_next(word.pair.s0));

  // ******************************
  // sync state
  // ******************************

  always_ff @(posedge adc_os_clk) begin
    if (adc_os_rst) begin
      pn_oos <= 1'b1;
      pn_err <= 1'b0;
      run <= '0;
    end else if (valid) begin
      // oos counts matches, in sync counts mismatches
      if (match != pn_oos) begin
        run <= '0;
      end else if (run == pn_lock_count - 3'd1) begin
        pn_oos <= ~pn_oos;
        run <= '0;
      end else begin
        run <= run + 3'd1;
      end
      // sticky, only a mismatch while locked counts
      if (!pn_oos && !match) begin
        pn_err <= 1'b1;
      end
    end
  end

  // history for the next compare
  always_ff @(posedge adc_os_clk) begin
    if (valid) begin
      last_s1 <= word.pair.s1;
    end
  end

endmodule

// File: rx_os_channel/rx_os_channel.sv
// receive channel with format conversion, over-range, pn check and channel registers
module rx_os_channel import rx_os_pkg::*; #(
  parameter logic [5:0] block_id = blk_chan0
) (
  input  logic         adc_os_clk,
  input  logic         adc_os_rst,
  input  logic         adc_valid,
  input  sample_word_t adc_data,
  output logic         dma_valid,
  output sample_word_t dma_data,
  output logic         dma_enable,
  output chan_status_t status,
  input  logic         up_clk,
  input  logic         up_rstn,
  input  up_req_t      up_req,
  output up_rsp_t      up_rsp
);

  // control register, up domain
  logic         up_enable;
  logic         up_format;
  // control after crossing, {format, enable}
  logic [1:0]   adc_ctrl;
  logic         adc_format;
  // converted word, before the output stage
  sample_word_t conv;
  // adc side status
  logic         pn_err;
  logic         pn_oos;
  logic         over_range;
  chan_status_t adc_status;
  // this block addressed
  logic         wsel;
  logic         rsel;

  // ******************************
  // control crossing
  // ******************************

  rx_os_level_sync #(.width(2)) i_ctrl_sync (
    .clk (adc_os_clk),
    .d   ({up_format, up_enable}),
    .q   (adc_ctrl)
  );

  assign dma_enable = adc_ctrl[0];
  assign adc_format = adc_ctrl[1];

  // ******************************
  // datapath
  // ******************************

  // sample at full scale either way
  function automatic logic at_limit(input logic [15:0] s);
    return (s == 16'h7fff) || (s == 16'h8000);
  endfunction

  // offset binary to two's complement, flip each msb
  always_comb begin
    conv = adc_data;
    conv.pair.s1[15] = adc_data.pair.s1[15] ^ adc_format;
    conv.pair.s0[15] = adc_data.pair.s0[15] ^ adc_format;
  end

  // one register stage to the dma side
  always_ff @(posedge adc_os_clk) begin
    if (adc_os_rst) begin
      dma_valid <= 1'b0;
      over_range <= 1'b0;
    end else begin
      dma_valid <= adc_valid;
      if (adc_valid && (at_limit(conv.pair.s0) || at_limit(conv.pair.s1))) begin
        over_range <= 1'b1;
      end
    end
  end

  always_ff @(posedge adc_os_clk) begin
    dma_data <= conv;
  end

  // pattern check on the incoming word
  rx_os_pn_mon i_pn_mon (
    .adc_os_clk (adc_os_clk),
    .adc_os_rst (adc_os_rst),
    .valid      (adc_valid),
    .word       (adc_data),
    .pn_err     (pn_err),
    .pn_oos     (pn_oos)
  );

  // ******************************
  // status crossing
  // ******************************

  assign adc_status = '{pn_err: pn_err, pn_oos: pn_oos, over_range: over_range};

  rx_os_level_sync #(.width(3)) i_status_sync (
    .clk (up_clk),
    .d   (adc_status),
    .q   (status)
  );

  // ******************************
  // register access
  // ******************************

  assign wsel = up_req.wreq && (up_req.waddr[13:8] == block_id);
  assign rsel = up_req.rreq && (up_req.raddr[13:8] == block_id);

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_enable <= 1'b0;
      up_format <= 1'b0;
      up_rsp <= '0;
    end else begin
      up_rsp.wack <= wsel;
      up_rsp.rack <= rsel;
      if (wsel && (up_req.waddr[7:0] == reg_chan_ctrl)) begin
        up_enable <= up_req.wdata[0];
        up_format <= up_req.wdata[1];
      end
      // rdata stays zero unless this block is read
      if (rsel) begin
        case (up_req.raddr[7:0])
          reg_chan_ctrl:   up_rsp.rdata <= {30'd0, up_format, up_enable};
          reg_chan_status: up_rsp.rdata <= {29'd0, status.over_range, status.pn_oos,
                                            status.pn_err};
          default:         up_rsp.rdata <= '0;
        endcase
      end else begin
        up_rsp.rdata <= '0;
      end
    end
  end

endmodule

// File: hw/rx_os_common.sv
// common registers, datapath reset control and sticky dma overflow and underflow flags
module rx_os_common import rx_os_pkg::*; (
  input  logic         adc_os_clk,
  output logic         adc_os_rst,
  input  logic         adc_os_dovf,
  input  logic         adc_os_dunf,
  input  chan_status_t up_status,
  input  logic         up_clk,
  input  logic         up_rstn,
  input  up_req_t      up_req,
  output up_rsp_t      up_rsp
);

  // registers, up domain
  logic [31:0] up_scratch;
  logic        up_rst_release;
  logic        up_dovf;
  logic        up_dunf;
  // release after crossing
  logic        adc_rst_release;
  // dma levels after crossing, {dunf, dovf}
  logic [1:0]  up_dma_s;
  // decode
  logic        wsel;
  logic        rsel;
  logic        dma_clr;

  // ******************************
  // datapath reset
  // ******************************

  rx_os_level_sync #(.width(1)) i_rst_sync (
    .clk (adc_os_clk),
    .d   (up_rst_release),
    .q   (adc_rst_release)
  );

  // held until software releases it
  assign adc_os_rst = ~adc_rst_release;

  // ******************************
  // dma flags
  // ******************************

  // a flag must stay up for at least one up_clk period
  rx_os_level_sync #(.width(2)) i_dma_sync (
    .clk (up_clk),
    .d   ({adc_os_dunf, adc_os_dovf}),
    .q   (up_dma_s)
  );

  // ******************************
  // register access
  // ******************************

  assign wsel = up_req.wreq && (up_req.waddr[13:8] == blk_common);
  assign rsel = up_req.rreq && (up_req.raddr[13:8] == blk_common);
  assign dma_clr = wsel && (up_req.waddr[7:0] == reg_dma_status);

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_scratch <= '0;
      up_rst_release <= 1'b0;
      up_dovf <= 1'b0;
      up_dunf <= 1'b0;
      up_rsp <= '0;
    end else begin
      up_rsp.wack <= wsel;
      up_rsp.rack <= rsel;
      if (wsel && (up_req.waddr[7:0] == reg_scratch)) begin
        up_scratch <= up_req.wdata;
      end
      if (wsel && (up_req.waddr[7:0] == reg_rst_ctrl)) begin
        up_rst_release <= up_req.wdata[0];
      end
      // write 1 to clear, a new event wins
      up_dovf <= up_dma_s[0] | (up_dovf & ~(dma_clr & up_req.wdata[0]));
      up_dunf <= up_dma_s[1] | (up_dunf & ~(dma_clr & up_req.wdata[1]));
      if (rsel) begin
        case (up_req.raddr[7:0])
          reg_version:    up_rsp.rdata <= rx_os_version;
          reg_scratch:    up_rsp.rdata <= up_scratch;
          reg_rst_ctrl:   up_rsp.rdata <= {31'd0, up_rst_release};
          reg_status:     up_rsp.rdata <= {29'd0, up_status.over_range, up_status.pn_oos,
                                           up_status.pn_err};
          reg_dma_status: up_rsp.rdata <= {30'd0, up_dunf, up_dovf};
          default:        up_rsp.rdata <= '0;
        endcase
      end else begin
        up_rsp.rdata <= '0;
      end
    end
  end

endmodule

// File: hw/rx_os.sv
// rx_os top level with i and q channels, common block and merge of bus responses and status
module rx_os import rx_os_pkg::*; (
  // adc side
  output logic        adc_os_rst,
  input  logic        adc_os_clk,
  input  logic        adc_os_valid,
  input  logic [63:0] adc_os_data,
  // dma side
  output logic        adc_os_enable_i0,
  output logic        adc_os_valid_i0,
  output logic [31:0] adc_os_data_i0,
  output logic        adc_os_enable_q0,
  output logic        adc_os_valid_q0,
  output logic [31:0] adc_os_data_q0,
  input  logic        adc_os_dovf,
  input  logic        adc_os_dunf,
  // processor bus
  input  logic        up_rstn,
  input  logic        up_clk,
  input  logic        up_wreq,
  input  logic [13:0] up_waddr,
  input  logic [31:0] up_wdata,
  output logic        up_wack,
  input  logic        up_rreq,
  input  logic [13:0] up_raddr,
  output logic [31:0] up_rdata,
  output logic        up_rack
);

  // bus request shared by all peers
  up_req_t      up_req;
  // one response per peer
  up_rsp_t      rsp_chan0;
  up_rsp_t      rsp_chan1;
  up_rsp_t      rsp_common;
  // channel status, up domain
  chan_status_t status_chan0;
  chan_status_t status_chan1;
  // merged status for the common block
  chan_status_t up_status;

  assign up_req = '{wreq: up_wreq, waddr: up_waddr, wdata: up_wdata,
                    rreq: up_rreq, raddr: up_raddr};

  // ******************************
  // channels
  // ******************************

  // i on the low half of the sample word
  rx_os_channel #(.block_id(blk_chan0)) i_chan0 (
    .adc_os_clk (adc_os_clk),
    .adc_os_rst (adc_os_rst),
    .adc_valid  (adc_os_valid),
    .adc_data   (adc_os_data[31:0]),
    .dma_valid  (adc_os_valid_i0),
    .dma_data   (adc_os_data_i0),
    .dma_enable (adc_os_enable_i0),
    .status     (status_chan0),
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .up_req     (up_req),
    .up_rsp     (rsp_chan0)
  );

  // q on the high half
  rx_os_channel #(.block_id(blk_chan1)) i_chan1 (
    .adc_os_clk (adc_os_clk),
    .adc_os_rst (adc_os_rst),
    .adc_valid  (adc_os_valid),
    .adc_data   (adc_os_data[63:32]),
    .dma_valid  (adc_os_valid_q0),
    .dma_data   (adc_os_data_q0),
    .dma_enable (adc_os_enable_q0),
    .status     (status_chan1),
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .up_req     (up_req),
    .up_rsp     (rsp_chan1)
  );

  // ******************************
  // common block
  // ******************************

  rx_os_common i_common (
    .adc_os_clk  (adc_os_clk),
    .adc_os_rst  (adc_os_rst),
    .adc_os_dovf (adc_os_dovf),
    .adc_os_dunf (adc_os_dunf),
    .up_status   (up_status),
    .up_clk      (up_clk),
    .up_rstn     (up_rstn),
    .up_req      (up_req),
    .up_rsp      (rsp_common)
  );

  // single master, unaddressed peers answer zero so OR is enough
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack <= 1'b0;
      up_rack <= 1'b0;
      up_rdata <= '0;
      up_status <= '0;
    end else begin
      up_wack <= rsp_chan0.wack | rsp_chan1.wack | rsp_common.wack;
      up_rack <= rsp_chan0.rack | rsp_chan1.rack | rsp_common.rack;
      up_rdata <= rsp_chan0.rdata | rsp_chan1.rdata | rsp_common.rdata;
      up_status <= status_chan0 | status_chan1;
    end
  end

endmodule

// File: tb/rx_os_checker.sv
// bound assertions on the rx_os bus handshake and datapath valid outputs
module rx_os_checker import rx_os_pkg::*; (
  input logic        up_clk,
  input logic        up_rstn,
  input logic        up_wreq,
  input logic [13:0] up_waddr,
  input logic        up_rreq,
  input logic [13:0] up_raddr,
  input logic        up_wack,
  input logic        up_rack,
  input logic [31:0] up_rdata,
  input logic        adc_os_clk,
  input logic        adc_os_rst,
  input logic        adc_os_valid_i0,
  input logic        adc_os_valid_q0
);
  timeunit 1ns;
  timeprecision 100ps;

  // failed assertions, read by the testbench at the end
  int unsigned fail_count = 0;

  // block number belongs to one of the three peers
  function automatic logic mapped(input logic [13:0] addr);
    return addr[13:8] inside {blk_common, blk_chan0, blk_chan1};
  endfunction

  // ******************************
  // bus handshake
  // ******************************

  // acks are one cycle wide
  wack_pulse: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_wack |=> !up_wack) else begin
    $error("up_wack held for more than one cycle");
    fail_count++;
  end

  rack_pulse: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_rack |=> !up_rack) else begin
    $error("up_rack held for more than one cycle");
    fail_count++;
  end

  // mapped request answered two edges later, and only then
  wack_latency: assert property (@(posedge up_clk) disable iff (!up_rstn)
    (up_wreq && mapped(up_waddr) |-> ##2 up_wack) and
    (up_wack |-> $past(up_wreq, 2))) else begin
    $error("up_wack not two cycles after a write request");
    fail_count++;
  end

  rack_latency: assert property (@(posedge up_clk) disable iff (!up_rstn)
    (up_rreq && mapped(up_raddr) |-> ##2 up_rack) and
    (up_rack |-> $past(up_rreq, 2))) else begin
    $error("up_rack not two cycles after a read request");
    fail_count++;
  end

  // merged rdata is quiet between reads
  rdata_quiet: assert property (@(posedge up_clk) disable iff (!up_rstn)
    !up_rack |-> (up_rdata == '0)) else begin
    $error("up_rdata nonzero without up_rack");
    fail_count++;
  end

  // ******************************
  // datapath
  // ******************************

  valid_in_reset: assert property (@(posedge adc_os_clk) disable iff (!up_rstn)
    adc_os_rst |-> (!adc_os_valid_i0 && !adc_os_valid_q0)) else begin
    $error("valid output high while the datapath is in reset");
    fail_count++;
  end

endmodule

bind rx_os rx_os_checker protocol_check (
  .up_clk          (up_clk),
  .up_rstn         (up_rstn),
  .up_wreq         (up_wreq),
  .up_waddr        (up_waddr),
  .up_rreq         (up_rreq),
  .up_raddr        (up_raddr),
  .up_wack         (up_wack),
  .up_rack         (up_rack),
  .up_rdata        (up_rdata),
  .adc_os_clk      (adc_os_clk),
  .adc_os_rst      (adc_os_rst),
  .adc_os_valid_i0 (adc_os_valid_i0),
  .adc_os_valid_q0 (adc_os_valid_q0)
);

// File: tb/rx_os_tb.sv
// rx_os testbench with clocks, stimulus, reference functions, compare tasks and watchdog
module rx_os_tb import rx_os_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period = 20;
  localparam int reset_cycles = 8;
  localparam int n_random = 200;
  localparam int n_format = 50;
  localparam int n_pn = 16;
  localparam int n_bus_ops = 60;
  // a bus op polls up to 10 reads of about 4 cycles
  localparam int test_cycles = reset_cycles + 2 * (n_random + n_format + 2 * n_pn) +
                               40 * n_bus_ops;
  localparam int watchdog_ns = (test_cycles + 1000) * clk_period;

  logic         up_clk;
  logic         up_rstn;
  logic         up_wreq;
  logic [13:0]  up_waddr;
  logic [31:0]  up_wdata;
  logic         up_wack;
  logic         up_rreq;
  logic [13:0]  up_raddr;
  logic [31:0]  up_rdata;
  logic         up_rack;
  logic         adc_os_clk;
  logic         adc_os_rst;
  logic         adc_os_valid;
  logic [63:0]  adc_os_data;
  logic         adc_os_dovf;
  logic         adc_os_dunf;
  logic         adc_os_enable_i0;
  logic         adc_os_valid_i0;
  logic [31:0]  adc_os_data_i0;
  logic         adc_os_enable_q0;
  logic         adc_os_valid_q0;
  logic [31:0]  adc_os_data_q0;

  // expected output words per channel
  sample_word_t exp_i[$];
  sample_word_t exp_q[$];
  // model of format bits and sticky status
  logic         fmt [2];
  chan_status_t exp_st [2];
  // last s1 of the clean pn stream
  logic [15:0]  pn_state;
  integer       seed;
  int           val_errors = 0;
  int           other_errors = 0;

  rx_os rx_os_inst (
    .adc_os_rst       (adc_os_rst),
    .adc_os_clk       (adc_os_clk),
    .adc_os_valid     (adc_os_valid),
    .adc_os_data      (adc_os_data),
    .adc_os_enable_i0 (adc_os_enable_i0),
    .adc_os_valid_i0  (adc_os_valid_i0),
    .adc_os_data_i0   (adc_os_data_i0),
    .adc_os_enable_q0 (adc_os_enable_q0),
    .adc_os_valid_q0  (adc_os_valid_q0),
    .adc_os_data_q0   (adc_os_data_q0),
    .adc_os_dovf      (adc_os_dovf),
    .adc_os_dunf      (adc_os_dunf),
    .up_rstn          (up_rstn),
    .up_clk           (up_clk),
    .up_wreq          (up_wreq),
    .up_waddr         (up_waddr),
    .up_wdata         (up_wdata),
    .up_wack          (up_wack),
    .up_rreq          (up_rreq),
    .up_raddr         (up_raddr),
    .up_rdata         (up_rdata),
    .up_rack          (up_rack)
  );

  // ******************************
  // clocks
  // ******************************

  initial begin
    up_clk = 1'b0;
    adc_os_clk = 1'b0;
  end

  always #(clk_period / 2) up_clk = ~up_clk;

  // adc clock lags by 7 ns
  always begin
    if ($time == 0) begin
      #7;
    end
    #(clk_period / 2) adc_os_clk = ~adc_os_clk;
  end

  // ******************************
  // reference model
  // ******************************

  // taps x^15+x^14+1 with the older bits at the higher index
  // each new bit k is bit k+14 xor bit k+15
  function automatic logic [15:0] pn15_next(input logic [15:0] prev);
    logic [31:0] seq;
    seq = {prev, 16'h0000};
    for (int k = 15; k >= 0; k--) begin
      seq[k] = seq[k + 14] ^ seq[k + 15];
    end
    return seq[15:0];
  endfunction

  // offset binary flips the sign bit of both samples
  function automatic sample_word_t format_word(input sample_word_t w, input logic fmt_on);
    sample_word_t r;
    r.raw = fmt_on ? (w.raw ^ 32'h8000_8000) : w.raw;
    return r;
  endfunction

  function automatic logic over_range_of(input sample_word_t w);
    return (w.pair.s0 inside {16'h7fff, 16'h8000}) || (w.pair.s1 inside {16'h7fff, 16'h8000});
  endfunction

  // ******************************
  // compare tasks
  // ******************************

  task automatic check_word(input sample_word_t got, input sample_word_t exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got.raw, exp.raw);
      val_errors++;
    end
  endtask

  task automatic check_status(input chan_status_t got, input chan_status_t exp,
                              input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got err/oos/or %b%b%b expected %b%b%b", $time, what,
               got.pn_err, got.pn_oos, got.over_range, exp.pn_err, exp.pn_oos, exp.over_range);
      val_errors++;
    end
  endtask

  task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s read %h expected %h", $time, what, got, exp);
      val_errors++;
    end
  endtask

  task automatic check_enables(input logic exp_i0, input logic exp_q0, input string what);
    if (adc_os_enable_i0 !== exp_i0 || adc_os_enable_q0 !== exp_q0) begin
      $display("CHECK FAILED at %0t: %s enables i/q %b%b expected %b%b", $time, what,
               adc_os_enable_i0, adc_os_enable_q0, exp_i0, exp_q0);
      val_errors++;
    end
  endtask

  task automatic check_dp_reset(input logic exp, input string what);
    if (adc_os_rst !== exp) begin
      $display("CHECK FAILED at %0t: %s adc_os_rst %b expected %b", $time, what,
               adc_os_rst, exp);
      val_errors++;
    end
  endtask

  // sampled at the falling edge away from the register updates
  always @(negedge adc_os_clk) begin
    if (adc_os_valid_i0 === 1'b1) begin
      if (exp_i.size() == 0) begin
        $display("unexpected valid word on the I channel at %0t", $time);
        other_errors++;
      end else begin
        check_word(adc_os_data_i0, exp_i.pop_front(), "I data");
      end
    end
    if (adc_os_valid_q0 === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("unexpected valid word on the Q channel at %0t", $time);
        other_errors++;
      end else begin
        check_word(adc_os_data_q0, exp_q.pop_front(), "Q data");
      end
    end
  end

  // ******************************
  // bus and stimulus tasks
  // ******************************

  task automatic up_wait(input int n);
    repeat (n) @(posedge up_clk);
    #1;
  endtask

  task automatic adc_wait(input int n);
    repeat (n) @(posedge adc_os_clk);
    #1;
  endtask

  task automatic write_reg(input logic [13:0] addr, input logic [31:0] data);
    int n;
    up_wait(1);
    up_wreq = 1'b1;
    up_waddr = addr;
    up_wdata = data;
    up_wait(1);
    up_wreq = 1'b0;
    n = 1;
    while (up_wack !== 1'b1 && n < 4) begin
      up_wait(1);
      n++;
    end
    if (up_wack !== 1'b1) begin
      $display("timeout: no write acknowledge from address %h at %0t", addr, $time);
      other_errors++;
    end
  endtask

  task automatic read_reg(input logic [13:0] addr, output logic [31:0] data, output bit acked);
    int n;
    up_wait(1);
    up_rreq = 1'b1;
    up_raddr = addr;
    up_wait(1);
    up_rreq = 1'b0;
    n = 1;
    while (up_rack !== 1'b1 && n < 4) begin
      up_wait(1);
      n++;
    end
    acked = (up_rack === 1'b1);
    data = up_rdata;
  endtask

  // polls while status crosses clocks and then compares
  task automatic expect_reg(input logic [13:0] addr, input logic [31:0] exp, input string what);
    logic [31:0] rd;
    bit          acked;
    int          tries;
    tries = 0;
    do begin
      read_reg(addr, rd, acked);
      tries++;
    end while (acked && rd !== exp && tries < 10);
    if (!acked) begin
      $display("timeout: no read acknowledge for %s at %0t", what, $time);
      other_errors++;
    end else begin
      check_reg(rd, exp, what);
    end
  endtask

  task automatic expect_status(input logic [13:0] addr, input chan_status_t exp,
                               input string what);
    logic [31:0]  rd;
    bit           acked;
    int           tries;
    chan_status_t got;
    tries = 0;
    do begin
      read_reg(addr, rd, acked);
      got = '{pn_err: rd[0], pn_oos: rd[1], over_range: rd[2]};
      tries++;
    end while (acked && got !== exp && tries < 10);
    if (!acked) begin
      $display("timeout: no read acknowledge for %s at %0t", what, $time);
      other_errors++;
    end else begin
      check_status(got, exp, what);
    end
  endtask

  // both channels and the merged common view
  task automatic expect_all_status(input string what);
    chan_status_t merged;
    merged = exp_st[0] | exp_st[1];
    expect_status({blk_chan0, reg_chan_status}, exp_st[0], {what, " chan0"});
    expect_status({blk_chan1, reg_chan_status}, exp_st[1], {what, " chan1"});
    expect_status({blk_common, reg_status}, merged, {what, " common"});
  endtask

  task automatic send_word(input logic [63:0] d);
    sample_word_t wi;
    sample_word_t wq;
    adc_wait(1);
    adc_os_valid = 1'b1;
    adc_os_data = d;
    wi = format_word(d[31:0], fmt[0]);
    wq = format_word(d[63:32], fmt[1]);
    exp_i.push_back(wi);
    exp_q.push_back(wq);
    // over-range is sticky until the datapath reset
    if (over_range_of(wi)) begin
      exp_st[0].over_range = 1'b1;
    end
    if (over_range_of(wq)) begin
      exp_st[1].over_range = 1'b1;
    end
  endtask

  // same pn word on both channels
  // corrupt flips one bit of s0
  task automatic send_pn_word(input bit corrupt);
    logic [15:0] s0;
    logic [15:0] s1;
    s0 = pn15_next(pn_state);
    s1 = pn15_next(s0);
    pn_state = s1;
    if (corrupt) begin
      s0 = s0 ^ 16'h0010;
    end
    send_word({s1, s0, s1, s0});
  endtask

  // outputs lag their input by one register stage
  task automatic drain_outputs();
    int n;
    adc_wait(1);
    adc_os_valid = 1'b0;
    n = 0;
    while ((exp_i.size() != 0 || exp_q.size() != 0) && n < 1) begin
      adc_wait(1);
      n++;
    end
    if (exp_i.size() != 0 || exp_q.size() != 0) begin
      $display("output words missing one cycle after their input at %0t", $time);
      other_errors++;
      exp_i.delete();
      exp_q.delete();
    end
  endtask

  // hold then release the datapath
  // words sent while held must not come out
  task automatic restart_datapath();
    write_reg({blk_common, reg_rst_ctrl}, 32'h0);
    adc_wait(6);
    check_dp_reset(1'b1, "datapath held");
    adc_os_valid = 1'b1;
    adc_os_data = {$random(seed), $random(seed)};
    adc_wait(4);
    adc_os_valid = 1'b0;
    write_reg({blk_common, reg_rst_ctrl}, 32'h1);
    adc_wait(6);
    check_dp_reset(1'b0, "datapath released");
    // status returns to reset values
    for (int c = 0; c < 2; c++) begin
      exp_st[c] = '{pn_err: 1'b0, pn_oos: 1'b1, over_range: 1'b0};
    end
  endtask

  task automatic pulse_dma(input logic ovf, input logic unf);
    adc_wait(1);
    adc_os_dovf = ovf;
    adc_os_dunf = unf;
    adc_wait(2);
    adc_os_dovf = 1'b0;
    adc_os_dunf = 1'b0;
  endtask

  // ******************************
  // test sequence
  // ******************************

  initial begin
    logic [31:0] rd;
    bit          acked;
    up_rstn = 1'b0;
    up_wreq = 1'b0;
    up_waddr = '0;
    up_wdata = '0;
    up_rreq = 1'b0;
    up_raddr = '0;
    adc_os_valid = 1'b0;
    adc_os_data = '0;
    adc_os_dovf = 1'b0;
    adc_os_dunf = 1'b0;
    fmt[0] = 1'b0;
    fmt[1] = 1'b0;
    exp_st[0] = '{pn_err: 1'b0, pn_oos: 1'b1, over_range: 1'b0};
    exp_st[1] = '{pn_err: 1'b0, pn_oos: 1'b1, over_range: 1'b0};
    pn_state = 16'hace1;
    seed = 32'h6e7c;
    repeat (reset_cycles) @(posedge up_clk);
    #1;
    up_rstn = 1'b1;
    up_wait(4);

    // outputs idle and datapath held after reset
    check_enables(1'b0, 1'b0, "enables after reset");
    check_dp_reset(1'b1, "datapath after reset");
    if (up_wack !== 1'b0 || up_rack !== 1'b0) begin
      $display("acknowledge high after reset at %0t", $time);
      other_errors++;
    end

    // register access
    expect_reg({blk_common, reg_version}, rx_os_version, "version");
    write_reg({blk_common, reg_scratch}, 32'h5a3c_96e1);
    expect_reg({blk_common, reg_scratch}, 32'h5a3c_96e1, "scratch");
    expect_reg({blk_common, reg_rst_ctrl}, 32'h0, "rst_ctrl after reset");
    write_reg({blk_common, reg_rst_ctrl}, 32'h1);
    adc_wait(6);
    check_dp_reset(1'b0, "datapath released");
    expect_reg({blk_common, reg_rst_ctrl}, 32'h1, "rst_ctrl released");
    read_reg({6'h3f, 8'h00}, rd, acked);
    if (acked) begin
      $display("unmapped block 0x3f acknowledged a read at %0t", $time);
      other_errors++;
    end

    // enables one channel at a time
    write_reg({blk_chan0, reg_chan_ctrl}, 32'h1);
    adc_wait(6);
    check_enables(1'b1, 1'b0, "chan0 enabled");
    write_reg({blk_chan1, reg_chan_ctrl}, 32'h1);
    write_reg({blk_chan0, reg_chan_ctrl}, 32'h0);
    adc_wait(6);
    check_enables(1'b0, 1'b1, "chan1 enabled only");
    write_reg({blk_chan0, reg_chan_ctrl}, 32'h1);
    adc_wait(6);
    check_enables(1'b1, 1'b1, "both enabled");

    // random words pass unchanged
    for (int i = 0; i < n_random; i++) begin
      send_word({$random(seed), $random(seed)});
    end
    drain_outputs();

    // offset binary on the Q channel only
    write_reg({blk_chan1, reg_chan_ctrl}, 32'h3);
    fmt[1] = 1'b1;
    adc_wait(6);
    for (int i = 0; i < n_format; i++) begin
      send_word({$random(seed), $random(seed)});
    end
    drain_outputs();
    write_reg({blk_chan1, reg_chan_ctrl}, 32'h1);
    fmt[1] = 1'b0;
    adc_wait(6);

    // pn15 lock then a single error and loss of lock
    restart_datapath();
    for (int i = 0; i < n_pn; i++) begin
      send_pn_word(1'b0);
    end
    drain_outputs();
    exp_st[0].pn_oos = 1'b0;
    exp_st[1].pn_oos = 1'b0;
    expect_all_status("pn locked");
    send_pn_word(1'b1);
    repeat (4) send_pn_word(1'b0);
    drain_outputs();
    exp_st[0].pn_err = 1'b1;
    exp_st[1].pn_err = 1'b1;
    expect_all_status("pn error");
    for (int i = 0; i < pn_lock_count + 2; i++) begin
      send_word({$random(seed), $random(seed)});
    end
    drain_outputs();
    exp_st[0].pn_oos = 1'b1;
    exp_st[1].pn_oos = 1'b1;
    expect_all_status("pn lost");

    // full scale on I only
    restart_datapath();
    send_word({32'h1234_5678, 16'h0100, 16'h7fff});
    drain_outputs();
    expect_all_status("over-range set");
    restart_datapath();
    expect_all_status("over-range cleared");

    // sticky dma flags cleared by writing 1
    pulse_dma(1'b1, 1'b0);
    expect_reg({blk_common, reg_dma_status}, 32'h1, "dma overflow set");
    pulse_dma(1'b0, 1'b1);
    expect_reg({blk_common, reg_dma_status}, 32'h3, "dma underflow set");
    up_wait(10);
    expect_reg({blk_common, reg_dma_status}, 32'h3, "dma flags held");
    write_reg({blk_common, reg_dma_status}, 32'h1);
    expect_reg({blk_common, reg_dma_status}, 32'h2, "dma overflow cleared");
    write_reg({blk_common, reg_dma_status}, 32'h2);
    expect_reg({blk_common, reg_dma_status}, 32'h0, "dma underflow cleared");

    up_wait(4);
    $display("errors: %0d value, %0d timeout or protocol, %0d assertion", val_errors,
             other_errors, rx_os_inst.protocol_check.fail_count);
    if (val_errors == 0 && other_errors == 0 && rx_os_inst.protocol_check.fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // ******************************
  // watchdog
  // ******************************

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the test sequence did not finish", watchdog_ns);
    $display("errors: %0d value, %0d timeout or protocol", val_errors, other_errors);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: rx_os.f
common/rx_os_pkg.sv
hw/rx_os_level_sync.sv
rx_os_channel/rx_os_pn_mon.sv
rx_os_channel/rx_os_channel.sv
hw/rx_os_common.sv
hw/rx_os.sv
tb/rx_os_checker.sv
tb/rx_os_tb.sv
